/* rtl/mem_stage_consts.svh */
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// register and data path width
`define XLEN 64

// destination register number width
`define REGNO_W 5

// bytes per doubleword
`define BYTE_LANES 8

// request slots the memory side can hold
`define MEM_CREDITS 4

// wide enough to hold MEM_CREDITS itself
`define CREDIT_W 3

`endif

/* rtl/mem_stage_pkg.sv */
`default_nettype none
`include "mem_stage_consts.svh"

package mem_stage_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`REGNO_W-1:0]    regno_t;
  typedef logic [`BYTE_LANES-1:0] byte_en_t;
  typedef logic [`CREDIT_W-1:0]   credit_t;

  typedef enum logic [3:0] {
    op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
    op_sb, op_sh, op_sw, op_sd
  } mem_op_t;

  typedef enum logic [1:0] {
    st_idle, st_wait, st_drain
  } access_state_t;

  typedef struct packed {
    mem_op_t op;
    regno_t  rd_regno;
    logic    update_rd;
    xlen_t   alu_result;      // address for loads and stores
    xlen_t   rs2_value;       // store data
  } stage_in_t;

  typedef struct packed {
    logic     write;
    xlen_t    addr;           // doubleword aligned
    xlen_t    wdata;
    byte_en_t byte_en;
  } mem_req_t;

  typedef struct packed {
    logic    valid;
    mem_op_t op;
    regno_t  rd_regno;
    logic    update_rd;
    xlen_t   alu_result;
    xlen_t   mdata;
  } stage_out_t;

endpackage

`default_nettype wire

/* rtl/mem_access_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_access_fsm import mem_stage_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    flush,
  input  logic    in_valid,
  input  mem_op_t op,
  input  logic    has_credit,
  input  logic    mem_resp_valid,
  output logic    issue,
  output logic    in_ready,
  output logic    capture
);

  access_state_t state;
  access_state_t state_nxt;
  logic          is_load;
  logic          is_store;

  assign is_load  = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  assign is_store = op inside {op_sb, op_sh, op_sw, op_sd};

  always_comb begin
    state_nxt = state;
    issue     = 1'b0;
    in_ready  = 1'b0;
    case (state)
      st_idle: begin
        if (in_valid && !flush) begin
          if (is_load || is_store) begin
            issue    = has_credit;
            in_ready = is_store && has_credit; // posted store
            if (is_load && has_credit) begin
              state_nxt = st_wait;
            end
          end else begin
            in_ready = 1'b1;
          end
        end
      end
      st_wait: begin
        if (flush) begin
          // a response in the flush cycle is simply dropped
          state_nxt = mem_resp_valid ? st_idle : st_drain;
        end else if (mem_resp_valid) begin
          in_ready  = in_valid;
          state_nxt = st_idle;
        end
      end
      st_drain: begin
        if (mem_resp_valid) begin
          state_nxt = st_idle; // swallow flushed load data
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  assign capture = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // only one load can be outstanding, so data never shows up unasked
  a_no_resp_in_idle: assert property (@(posedge clk) disable iff (reset)
    state == st_idle |-> !mem_resp_valid);

  // a waiting instruction stays put until it is taken
  a_hold_input: assert property (@(posedge clk) disable iff (reset)
    (in_valid && !in_ready && !flush) |=> (in_valid && $stable(op)));

endmodule

`default_nettype wire

/* rtl/mem_credit_counter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_consts.svh"

module mem_credit_counter import mem_stage_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic spend,
  input  logic credit_return,
  output logic has_credit
);

  credit_t count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= credit_t'(`MEM_CREDITS); // memory starts empty
    end else begin
      case ({spend, credit_return})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;       // none, or spend and return together
      endcase
    end
  end

  assign has_credit = (count != '0);

  // memory must not return more credits than were spent
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    (credit_return && !spend) |-> count < credit_t'(`MEM_CREDITS));

  a_credit_in_range: assert property (@(posedge clk) disable iff (reset)
    count <= credit_t'(`MEM_CREDITS));

  a_credit_min: assert property (@(posedge clk) disable iff (reset)
    spend |-> count != '0);

endmodule

`default_nettype wire

/* rtl/store_lane_packer.sv */
`timescale 1ns/10ps
`default_nettype none

module store_lane_packer import mem_stage_pkg::*; (
  input  stage_in_t instr,
  output mem_req_t  mem_req
);

  logic [2:0] lane;
  byte_en_t   lane_mask;
  xlen_t      sized_data;
  logic       is_store;

  // low address bits under the access size are dropped
  always_comb begin
    lane       = '0;
    lane_mask  = '0;
    sized_data = '0;
    case (instr.op)
      op_sb, op_lb, op_lbu: begin
        lane       = instr.alu_result[2:0];
        lane_mask  = 8'h01;
        sized_data = xlen_t'(instr.rs2_value[7:0]);
      end
      op_sh, op_lh, op_lhu: begin
        lane       = {instr.alu_result[2:1], 1'b0};
        lane_mask  = 8'h03;
        sized_data = xlen_t'(instr.rs2_value[15:0]);
      end
      op_sw, op_lw, op_lwu: begin
        lane       = {instr.alu_result[2], 2'b00};
        lane_mask  = 8'h0f;
        sized_data = xlen_t'(instr.rs2_value[31:0]);
      end
      op_sd, op_ld: begin
        lane_mask  = 8'hff;
        sized_data = instr.rs2_value;
      end
      default: begin
        lane_mask = '0; // not a memory op
      end
    endcase
  end

  assign is_store = instr.op inside {op_sb, op_sh, op_sw, op_sd};

  assign mem_req.write   = is_store;
  assign mem_req.addr    = {instr.alu_result[63:3], 3'b000};
  assign mem_req.byte_en = lane_mask << lane;
  assign mem_req.wdata   = is_store ? (sized_data << {lane, 3'b000}) : '0;

endmodule

`default_nettype wire

/* rtl/load_result_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module load_result_reg import mem_stage_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       capture,
  input  stage_in_t  instr,
  input  xlen_t      mem_resp_data,
  output stage_out_t result
);

  logic [2:0] lane;
  xlen_t      shifted;
  xlen_t      mdata;

  always_comb begin
    case (instr.op)
      op_lh, op_lhu: lane = {instr.alu_result[2:1], 1'b0};
      op_lw, op_lwu: lane = {instr.alu_result[2], 2'b00};
      op_ld:         lane = 3'b000;
      default:       lane = instr.alu_result[2:0];
    endcase
  end

  assign shifted = mem_resp_data >> {lane, 3'b000}; // addressed lane to bit 0

  always_comb begin
    case (instr.op)
      op_lb:   mdata = xlen_t'(signed'(shifted[7:0]));
      op_lbu:  mdata = xlen_t'(shifted[7:0]);
      op_lh:   mdata = xlen_t'(signed'(shifted[15:0]));
      op_lhu:  mdata = xlen_t'(shifted[15:0]);
      op_lw:   mdata = xlen_t'(signed'(shifted[31:0]));
      op_lwu:  mdata = xlen_t'(shifted[31:0]);
      op_ld:   mdata = shifted;
      default: mdata = '0; // stores and alu ops
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= capture; // single cycle pulse
      if (capture) begin
        result.op         <= instr.op;
        result.rd_regno   <= instr.rd_regno;
        result.update_rd  <= instr.update_rd;
        result.alu_result <= instr.alu_result;
        result.mdata      <= mdata;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage import mem_stage_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,

  // pipeline side
  input  logic       in_valid,
  input  stage_in_t  in_instr,
  output logic       in_ready,

  // memory side
  output logic       mem_req_valid,
  output mem_req_t   mem_req,
  input  logic       credit_return,
  input  logic       mem_resp_valid,
  input  xlen_t      mem_resp_data,

  // writeback side
  output stage_out_t result
);

  logic issue;
  logic has_credit;
  logic capture;

  mem_access_fsm u_fsm (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .in_valid       (in_valid),
    .op             (in_instr.op),
    .has_credit     (has_credit),
    .mem_resp_valid (mem_resp_valid),
    .issue          (issue),
    .in_ready       (in_ready),
    .capture        (capture)
  );

  mem_credit_counter u_credits (
    .clk           (clk),
    .reset         (reset),
    .spend         (issue),
    .credit_return (credit_return),
    .has_credit    (has_credit)
  );

  store_lane_packer u_packer (
    .instr   (in_instr),
    .mem_req (mem_req)
  );

  assign mem_req_valid = issue; // one cycle per request

  load_result_reg u_result (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .capture       (capture),
    .instr         (in_instr),
    .mem_resp_data (mem_resp_data),
    .result        (result)
  );

endmodule

`default_nettype wire

/* tests/mem_responder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_consts.svh"

module mem_responder import mem_stage_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     mem_req_valid,
  input  mem_req_t mem_req,
  output logic     credit_return,
  output logic     mem_resp_valid,
  output xlen_t    mem_resp_data
);

  xlen_t    mem [xlen_t];       // sparse doubleword storage
  mem_req_t pend [$];
  integer   seed;
  logic     active;
  int       delay;
  int       owed;               // retired but credit not yet returned
  int       hold;

  function automatic xlen_t read_word(xlen_t addr);
    if (mem.exists(addr)) return mem[addr];
    return (addr * 64'h9e37_79b9_7f4a_7c15) ^ {addr[31:0], addr[63:32]}; // fill pattern
  endfunction

  task automatic retire(input mem_req_t r);
    xlen_t word;
    int    i;
    word = read_word(r.addr);
    if (r.write) begin
      for (i = 0; i < `BYTE_LANES; i++) begin
        if (r.byte_en[i]) word[8*i +: 8] = r.wdata[8*i +: 8];
      end
      mem[r.addr] = word;
    end else begin
      mem_resp_valid = 1'b1;
      mem_resp_data  = word;
    end
    owed++;
  endtask

  initial begin
    seed           = 32'h637c_c0c6;
    active         = 1'b0;
    credit_return  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
  end

  always @(posedge clk) begin
    active = !reset;
    if (reset) pend.delete();
    else if (mem_req_valid) pend.push_back(mem_req); // requests kept in order
  end

  always @(negedge clk) begin
    credit_return  = 1'b0;
    mem_resp_valid = 1'b0;
    if (!active) begin
      owed  = 0;
      hold  = 0;
      delay = 0;
    end else begin
      if (pend.size() > 0) begin
        if (delay > 0) begin
          delay--;
        end else begin
          retire(pend.pop_front());
          delay = $unsigned($random(seed)) % 6;
        end
      end
      if (hold > 0) begin
        hold--;                 // credits withheld
      end else if (owed > 0) begin
        credit_return = 1'b1;
        owed--;
        if ($unsigned($random(seed)) % 8 == 0) hold = 2 + $unsigned($random(seed)) % 10;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none
`include "mem_stage_consts.svh"

module tb_mem_stage import mem_stage_pkg::*; ();

  localparam xlen_t window_base = 64'h9a40_0000_1234_5000;

  logic       clk;
  logic       reset;
  logic       flush;
  logic       in_valid;
  stage_in_t  in_instr;
  logic       in_ready;
  logic       mem_req_valid;
  mem_req_t   mem_req;
  logic       credit_return;
  logic       mem_resp_valid;
  xlen_t      mem_resp_data;
  stage_out_t result;

  integer     seed;
  logic [7:0] model_mem [xlen_t]; // byte level reference memory
  int         outstanding;
  logic       exp_valid;

  mem_stage dut0 (.*);
  mem_responder memory (.*);

  always #20 clk = ~clk;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input stage_out_t got, input stage_out_t exp);
    if (got !== exp) stop_with_error($sformatf("mismatch result: got %h expected %h", got, exp));
  endtask

  task automatic check_req(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) stop_with_error($sformatf("mismatch mem_req: got %h expected %h", got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
  endtask

  function automatic int access_size(input mem_op_t op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      op_ld, op_sd:         return 8;
      default:              return 0;
    endcase
  endfunction

  function automatic mem_req_t expected_req(input stage_in_t ins);
    mem_req_t req;
    int       size;
    int       first;
    int       i;
    size        = access_size(ins.op);
    first       = ins.alu_result[2:0] & ~(size - 1); // natural alignment
    req.write   = ins.op inside {op_sb, op_sh, op_sw, op_sd};
    req.addr    = ins.alu_result & ~xlen_t'(7);
    req.wdata   = '0;
    req.byte_en = '0;
    for (i = 0; i < size; i++) begin
      req.byte_en[first + i] = 1'b1;
      if (req.write) req.wdata[8*(first + i) +: 8] = ins.rs2_value[8*i +: 8];
    end
    return req;
  endfunction

  function automatic xlen_t model_load(input mem_op_t op, input xlen_t addr);
    xlen_t val;
    xlen_t base;
    int    size;
    int    i;
    size = access_size(op);
    base = addr & ~xlen_t'(size - 1);
    val  = '0;
    for (i = 0; i < size; i++) begin
      val[8*i +: 8] = model_mem.exists(base + i) ? model_mem[base + i] : 8'h00;
    end
    if (op inside {op_lb, op_lh, op_lw} && val[8*size-1]) val = val | (~xlen_t'(0) << (8*size));
    return val;
  endfunction

  task automatic model_store(input stage_in_t ins);
    xlen_t base;
    int    size;
    int    i;
    size = access_size(ins.op);
    base = ins.alu_result & ~xlen_t'(size - 1);
    for (i = 0; i < size; i++) model_mem[base + i] = ins.rs2_value[8*i +: 8];
  endtask

  function automatic stage_in_t random_instr(input mem_op_t op);
    stage_in_t ins;
    ins.op         = op;
    ins.rd_regno   = $random(seed);
    ins.update_rd  = $random(seed);
    ins.rs2_value  = {$random(seed), $random(seed)};
    ins.alu_result = (op == op_none) ? {$random(seed), $random(seed)} :
                     window_base + ($unsigned($random(seed)) & 32'h7f);
    return ins;
  endfunction

  // called on a falling edge, returns on the falling edge after the result check
  task automatic present_instr(input stage_in_t ins);
    stage_out_t exp;
    int         waited;
    in_valid = 1'b1;
    in_instr = ins;
    waited   = 0;
    @(posedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > 200) stop_with_error("instruction was not accepted within 200 cycles");
      @(posedge clk);
    end
    exp.valid      = 1'b1;
    exp.op         = ins.op;
    exp.rd_regno   = ins.rd_regno;
    exp.update_rd  = ins.update_rd;
    exp.alu_result = ins.alu_result;
    exp.mdata      = (access_size(ins.op) != 0 && ins.op < op_sb) ?
                     model_load(ins.op, ins.alu_result) : '0;
    if (ins.op >= op_sb) model_store(ins);
    @(negedge clk);
    in_valid = 1'b0;
    check_result(result, exp);
  endtask

  task automatic flush_pending_load(input stage_in_t ld);
    int waited;
    in_valid = 1'b1;
    in_instr = ld;
    waited   = 0;
    @(posedge clk);
    while (!mem_req_valid) begin
      waited++;
      if (waited > 200) stop_with_error("load was not issued within 200 cycles");
      @(posedge clk);
    end
    @(negedge clk);
    flush = 1'b1;           // lands before the earliest response edge
    @(negedge clk);
    flush    = 1'b0;
    in_valid = 1'b0;
    check_flag("result.valid", result.valid, 1'b0);
  endtask

  // request rules, credit bound and single cycle result valid
  always @(posedge clk) begin
    if (reset) begin
      outstanding = 0;
      exp_valid   = 1'b0;
    end else begin
      if (mem_req_valid) begin
        if (outstanding >= `MEM_CREDITS) stop_with_error("request issued with no credit left");
        check_req(mem_req, expected_req(in_instr));
      end
      outstanding = outstanding + mem_req_valid - credit_return;
      if (outstanding < 0) stop_with_error("credit returned with no request outstanding");
      exp_valid = in_valid && in_ready && !flush;
    end
  end

  always @(negedge clk) check_flag("result.valid", result.valid, exp_valid);

  initial begin
    stage_in_t ins;
    int        i;
    int        pick;
    int        waited;
    seed     = 32'h637c_c0c6;
    clk      = 1'b0;
    reset    = 1'b1;
    flush    = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    for (i = 0; i < 16; i++) begin
      ins            = random_instr(op_sd);
      ins.alu_result = window_base + 8 * i; // whole window gets known data
      present_instr(ins);
    end
    for (i = 0; i < 300; i++) begin
      pick = $unsigned($random(seed)) % 16;
      if (pick < 12) begin
        present_instr(random_instr(mem_op_t'(pick)));
      end else if (pick == 12) begin
        flush_pending_load(random_instr(mem_op_t'(1 + $unsigned($random(seed)) % 7)));
      end else begin
        repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      end
    end
    waited = 0;
    while (outstanding != 0) begin
      waited++;
      if (waited > 200) stop_with_error("memory requests still outstanding at end of run");
      @(negedge clk);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/mem_stage_pkg.sv
rtl/mem_access_fsm.sv
rtl/mem_credit_counter.sv
rtl/store_lane_packer.sv
rtl/load_result_reg.sv
rtl/mem_stage.sv
tests/mem_responder.sv
tests/tb_mem_stage.sv
